// File: filelist.f
+incdir+include
hw/ex_ops_pkg.sv
hw/ex_ctrl_pkg.sv
hw/alu32.sv
hw/mm_alu64.sv
hw/ptr_step_unit.sv
hw/execute.sv
hw/ex_wb_latch.sv
hw/execute_stage.sv
tests/execute_stage_tb.sv

// File: hw/alu32.sv
// 32-bit integer alu with logic ops, add and shifts.
`include "ex_params.svh"

module alu32 (
   input  logic [`EX_DATA_W-1:0] a,
   input  logic [`EX_DATA_W-1:0] b,
   input  ex_ops_pkg::alu_op_e   op,
   output logic [`EX_DATA_W-1:0] result
);
   import ex_ops_pkg::*;

   logic [4:0] shamt;

   assign shamt = b[4:0];   // shift amount, upper bits ignored.

   // --------------------------------------------------
   // op select.
   // --------------------------------------------------
   always_comb begin
      case (op)
         ADD:     result = a + b;
         OR:      result = a | b;
         AND:     result = a & b;
         NOT_A:   result = ~a;
         XOR:     result = a ^ b;
         SHL:     result = a << shamt;
         SHR:     result = a >> shamt;
         SAR:     result = $signed(a) >>> shamt;   // sign fill.
         default: result = '0;
      endcase
   end

endmodule

// File: hw/ex_ctrl_pkg.sv
// operand-select and pointer-step control enums.
package ex_ctrl_pkg;

   // operand size of the current instruction.
   // code 2'b11 is not used by decode.
   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,
      SZ_WORD  = 2'd1,
      SZ_DWORD = 2'd2
   } data_size_e;

   // source of the alu b operand.
   typedef enum logic {
      B_OPERAND = 1'b0,   // b from the bundle.
      B_TEMP    = 1'b1    // b from the temp register.
   } b_sel_e;

endpackage

// File: hw/ex_ops_pkg.sv
// alu and multimedia opcode enums.
package ex_ops_pkg;

   // integer alu ops, shifts take b[4:0].
   typedef enum logic [2:0] {
      ADD   = 3'd0,
      OR    = 3'd1,
      AND   = 3'd2,
      NOT_A = 3'd3,
      XOR   = 3'd4,
      SHL   = 3'd5,
      SHR   = 3'd6,
      SAR   = 3'd7
   } alu_op_e;

   // packed ops share the same 3-bit opcode field.
   typedef enum logic [2:0] {
      PADDB = 3'd0,
      PADDW = 3'd1,
      PADDD = 3'd2,
      PAND  = 3'd3,
      POR   = 3'd4,
      PXOR  = 3'd5,
      PSUBB = 3'd6,
      PSUBW = 3'd7
   } mm_op_e;

endpackage

// File: hw/ex_wb_latch.sv
// ex/wb pipeline register with valid and writeback enables.
`include "ex_params.svh"

module ex_wb_latch (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    in_valid,
   input  logic [`EX_DATA_W-1:0]   ex_next_eip,
   input  logic [15:0]             ex_next_cs,
   input  logic [`EX_CS_W-1:0]     ex_control_store,
   input  logic [`EX_DATA_W-1:0]   ex_sr1_data,
   input  logic [`EX_DATA_W-1:0]   ex_alu_result,
   input  logic [`EX_MM_W-1:0]     ex_mm_result,
   input  logic [`EX_DATA_W-1:0]   ex_sp_xchg_out,
   input  logic [`EX_DATA_W-1:0]   ex_mem_wr_addr,
   input  ex_ctrl_pkg::data_size_e ex_data_size,
   input  ex_ops_pkg::alu_op_e     ex_aluk,
   input  logic [2:0]              ex_drid1,
   input  logic [2:0]              ex_drid2,
   input  logic                    ex_mem_wr,
   input  logic                    ex_ld_gpr1,
   input  logic                    ex_ld_mm,
   output logic                    wb_valid,
   output logic [`EX_DATA_W-1:0]   wb_next_eip,
   output logic [15:0]             wb_next_cs,
   output logic [`EX_CS_W-1:0]     wb_control_store,
   output logic [`EX_DATA_W-1:0]   wb_sr1_data,
   output logic [`EX_DATA_W-1:0]   wb_alu_result,
   output logic [`EX_MM_W-1:0]     wb_mm_result,
   output logic [`EX_DATA_W-1:0]   wb_sp_xchg_out,
   output logic [`EX_DATA_W-1:0]   wb_mem_wr_addr,
   output ex_ctrl_pkg::data_size_e wb_data_size,
   output ex_ops_pkg::alu_op_e     wb_aluk,
   output logic [2:0]              wb_drid1,
   output logic [2:0]              wb_drid2,
   output logic                    wb_mem_wr,
   output logic                    wb_ld_gpr1,
   output logic                    wb_ld_mm
);

   // --------------------------------------------------
   // control, cleared on reset.
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid   <= 1'b0;
         wb_mem_wr  <= 1'b0;
         wb_ld_gpr1 <= 1'b0;
         wb_ld_mm   <= 1'b0;
      end else begin
         wb_valid   <= in_valid;
         wb_mem_wr  <= ex_mem_wr;
         wb_ld_gpr1 <= ex_ld_gpr1;
         wb_ld_mm   <= ex_ld_mm;
      end
   end

   // payload, loads every clock.
   always_ff @(posedge clk) begin
      wb_next_eip      <= ex_next_eip;
      wb_next_cs       <= ex_next_cs;
      wb_control_store <= ex_control_store;
      wb_sr1_data      <= ex_sr1_data;
      wb_alu_result    <= ex_alu_result;
      wb_mm_result     <= ex_mm_result;
      wb_sp_xchg_out   <= ex_sp_xchg_out;
      wb_mem_wr_addr   <= ex_mem_wr_addr;
      wb_data_size     <= ex_data_size;
      wb_aluk          <= ex_aluk;
      wb_drid1         <= ex_drid1;
      wb_drid2         <= ex_drid2;
   end

endmodule

// File: hw/execute.sv
// execute datapath: control decode, temp register, muxes and alus.
`include "ex_params.svh"

module execute (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    valid,
   input  logic [`EX_DATA_W-1:0]   neip,
   input  logic [15:0]             ncs,
   input  logic [`EX_CS_W-1:0]     control_store,
   input  logic [`EX_DATA_W-1:0]   a,
   input  logic [`EX_DATA_W-1:0]   b,
   input  logic [`EX_MM_W-1:0]     mm_a,
   input  logic [`EX_MM_W-1:0]     mm_b,
   input  logic [`EX_DATA_W-1:0]   sp_xchg_data,
   input  ex_ctrl_pkg::data_size_e data_size,
   input  ex_ops_pkg::alu_op_e     aluk,
   input  logic                    df_flag,
   output logic [`EX_DATA_W-1:0]   next_eip,
   output logic [15:0]             next_cs,
   output logic [`EX_DATA_W-1:0]   sr1_data,
   output logic [`EX_DATA_W-1:0]   alu_result,
   output logic [`EX_MM_W-1:0]     mm_result,
   output logic [`EX_DATA_W-1:0]   sp_xchg_out
);
   import ex_ops_pkg::*;
   import ex_ctrl_pkg::*;

   logic sel_next_eip, sel_next_cs, sel_sr1, ld_temp, sp_pop, sp_xchg;
   b_sel_e b_sel;
   mm_op_e mm_op;

   logic [`EX_DATA_W-1:0] temp_q;
   logic [`EX_DATA_W-1:0] b_mux;
   logic [`EX_DATA_W-1:0] ptr_next, sp_next;

   // --------------------------------------------------
   // control-store decode.
   // --------------------------------------------------
   assign sel_next_eip = control_store[`EX_CS_NEXT_EIP];
   assign sel_next_cs  = control_store[`EX_CS_NEXT_CSEG];
   assign sel_sr1      = control_store[`EX_CS_SR1_SEL];
   assign ld_temp      = control_store[`EX_CS_LD_TEMP];
   assign b_sel        = b_sel_e'(control_store[`EX_CS_B_SEL]);
   assign sp_pop       = control_store[`EX_CS_SP_POP];
   assign sp_xchg      = control_store[`EX_CS_SP_XCHG];

   assign mm_op = mm_op_e'(aluk);   // same opcode field for both alus.

   // temp holds a for a later bundle.
   always_ff @(posedge clk) begin
      if (reset) begin
         temp_q <= '0;
      end else if (valid && ld_temp) begin
         temp_q <= a;
      end
   end

   assign b_mux = (b_sel == B_TEMP) ? temp_q : b;

   // jump target comes in on a.
   assign next_eip = sel_next_eip ? a : neip;
   assign next_cs  = sel_next_cs ? a[15:0] : ncs;

   ptr_step_unit u_ptr_step (
      .ptr      (b),
      .sp_data  (sp_xchg_data),
      .size     (data_size),
      .df_flag  (df_flag),
      .pop_en   (sp_pop),
      .ptr_next (ptr_next),
      .sp_next  (sp_next)
   );

   assign sr1_data    = sel_sr1 ? ptr_next : sp_xchg_data;
   assign sp_xchg_out = sp_xchg ? a : sp_next;   // xchg wins over pop.

   alu32 u_alu32 (
      .a      (a),
      .b      (b_mux),
      .op     (aluk),
      .result (alu_result)
   );

   mm_alu64 u_mm_alu64 (
      .a      (mm_a),
      .b      (mm_b),
      .op     (mm_op),
      .result (mm_result)
   );

endmodule

// File: hw/execute_stage.sv
// execute stage top: execute datapath and ex/wb register.
`include "ex_params.svh"

module execute_stage (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    in_valid,
   input  logic [`EX_DATA_W-1:0]   in_neip,
   input  logic [15:0]             in_ncs,
   input  logic [`EX_CS_W-1:0]     in_control_store,
   input  logic [`EX_DATA_W-1:0]   in_a,
   input  logic [`EX_DATA_W-1:0]   in_b,
   input  logic [`EX_MM_W-1:0]     in_mm_a,
   input  logic [`EX_MM_W-1:0]     in_mm_b,
   input  logic [`EX_DATA_W-1:0]   in_sp_xchg_data,
   input  logic [`EX_DATA_W-1:0]   in_mem_wr_addr,
   input  ex_ctrl_pkg::data_size_e in_data_size,
   input  ex_ops_pkg::alu_op_e     in_aluk,
   input  logic [2:0]              in_drid1,
   input  logic [2:0]              in_drid2,
   input  logic                    in_mem_wr,
   input  logic                    in_ld_gpr1,
   input  logic                    in_ld_mm,
   input  logic                    in_df_flag,
   output logic                    wb_valid,
   output logic [`EX_DATA_W-1:0]   wb_next_eip,
   output logic [15:0]             wb_next_cs,
   output logic [`EX_CS_W-1:0]     wb_control_store,
   output logic [`EX_DATA_W-1:0]   wb_sr1_data,
   output logic [`EX_DATA_W-1:0]   wb_alu_result,
   output logic [`EX_MM_W-1:0]     wb_mm_result,
   output logic [`EX_DATA_W-1:0]   wb_sp_xchg_out,
   output logic [`EX_DATA_W-1:0]   wb_mem_wr_addr,
   output ex_ctrl_pkg::data_size_e wb_data_size,
   output ex_ops_pkg::alu_op_e     wb_aluk,
   output logic [2:0]              wb_drid1,
   output logic [2:0]              wb_drid2,
   output logic                    wb_mem_wr,
   output logic                    wb_ld_gpr1,
   output logic                    wb_ld_mm
);

   logic [`EX_DATA_W-1:0] ex_next_eip, ex_sr1_data, ex_alu_result, ex_sp_xchg_out;
   logic [15:0]           ex_next_cs;
   logic [`EX_MM_W-1:0]   ex_mm_result;

   execute u_execute (
      .clk           (clk),
      .reset         (reset),
      .valid         (in_valid),
      .neip          (in_neip),
      .ncs           (in_ncs),
      .control_store (in_control_store),
      .a             (in_a),
      .b             (in_b),
      .mm_a          (in_mm_a),
      .mm_b          (in_mm_b),
      .sp_xchg_data  (in_sp_xchg_data),
      .data_size     (in_data_size),
      .aluk          (in_aluk),
      .df_flag       (in_df_flag),
      .next_eip      (ex_next_eip),
      .next_cs       (ex_next_cs),
      .sr1_data      (ex_sr1_data),
      .alu_result    (ex_alu_result),
      .mm_result     (ex_mm_result),
      .sp_xchg_out   (ex_sp_xchg_out)
   );

   // control store and pass-through fields go straight to the register.
   ex_wb_latch u_ex_wb_latch (
      .clk              (clk),
      .reset            (reset),
      .in_valid         (in_valid),
      .ex_next_eip      (ex_next_eip),
      .ex_next_cs       (ex_next_cs),
      .ex_control_store (in_control_store),
      .ex_sr1_data      (ex_sr1_data),
      .ex_alu_result    (ex_alu_result),
      .ex_mm_result     (ex_mm_result),
      .ex_sp_xchg_out   (ex_sp_xchg_out),
      .ex_mem_wr_addr   (in_mem_wr_addr),
      .ex_data_size     (in_data_size),
      .ex_aluk          (in_aluk),
      .ex_drid1         (in_drid1),
      .ex_drid2         (in_drid2),
      .ex_mem_wr        (in_mem_wr),
      .ex_ld_gpr1       (in_ld_gpr1),
      .ex_ld_mm         (in_ld_mm),
      .wb_valid         (wb_valid),
      .wb_next_eip      (wb_next_eip),
      .wb_next_cs       (wb_next_cs),
      .wb_control_store (wb_control_store),
      .wb_sr1_data      (wb_sr1_data),
      .wb_alu_result    (wb_alu_result),
      .wb_mm_result     (wb_mm_result),
      .wb_sp_xchg_out   (wb_sp_xchg_out),
      .wb_mem_wr_addr   (wb_mem_wr_addr),
      .wb_data_size     (wb_data_size),
      .wb_aluk          (wb_aluk),
      .wb_drid1         (wb_drid1),
      .wb_drid2         (wb_drid2),
      .wb_mem_wr        (wb_mem_wr),
      .wb_ld_gpr1       (wb_ld_gpr1),
      .wb_ld_mm         (wb_ld_mm)
   );

endmodule

// File: hw/mm_alu64.sv
// 64-bit packed multimedia alu, byte/word/dword lanes.
`include "ex_params.svh"

module mm_alu64 (
   input  logic [`EX_MM_W-1:0] a,
   input  logic [`EX_MM_W-1:0] b,
   input  ex_ops_pkg::mm_op_e  op,
   output logic [`EX_MM_W-1:0] result
);
   import ex_ops_pkg::*;

   logic [`EX_MM_W-1:0] add_b, add_w, add_d;
   logic [`EX_MM_W-1:0] sub_b, sub_w;

   // each lane is sliced out, so carries stop at the lane edge.
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         add_b[i*8 +: 8] = a[i*8 +: 8] + b[i*8 +: 8];
         sub_b[i*8 +: 8] = a[i*8 +: 8] - b[i*8 +: 8];
      end
      for (int j = 0; j < 4; j++) begin
         add_w[j*16 +: 16] = a[j*16 +: 16] + b[j*16 +: 16];
         sub_w[j*16 +: 16] = a[j*16 +: 16] - b[j*16 +: 16];
      end
      for (int k = 0; k < 2; k++) begin
         add_d[k*32 +: 32] = a[k*32 +: 32] + b[k*32 +: 32];
      end
   end

   always_comb begin
      case (op)
         PADDB:   result = add_b;
         PADDW:   result = add_w;
         PADDD:   result = add_d;
         PAND:    result = a & b;
         POR:     result = a | b;
         PXOR:    result = a ^ b;
         PSUBB:   result = sub_b;
         PSUBW:   result = sub_w;
         default: result = '0;
      endcase
   end

endmodule

// File: hw/ptr_step_unit.sv
// string-pointer step adder and stack-pop adder.
`include "ex_params.svh"

module ptr_step_unit (
   input  logic [`EX_DATA_W-1:0]   ptr,
   input  logic [`EX_DATA_W-1:0]   sp_data,
   input  ex_ctrl_pkg::data_size_e size,
   input  logic                    df_flag,
   input  logic                    pop_en,
   output logic [`EX_DATA_W-1:0]   ptr_next,
   output logic [`EX_DATA_W-1:0]   sp_next
);
   import ex_ctrl_pkg::*;

   logic [`EX_DATA_W-1:0] step_mag;
   logic [`EX_DATA_W-1:0] step;
   logic [`EX_DATA_W-1:0] pop_amt;

   // --------------------------------------------------
   // string step, +-1/2/4.
   // --------------------------------------------------
   always_comb begin
      case (size)
         SZ_BYTE:  step_mag = `EX_DATA_W'd1;
         SZ_WORD:  step_mag = `EX_DATA_W'd2;
         SZ_DWORD: step_mag = `EX_DATA_W'd4;
         default:  step_mag = '0;   // unused size code, no step.
      endcase
   end

   // df set walks the string downward.
   assign step     = df_flag ? (~step_mag + 1'b1) : step_mag;
   assign ptr_next = ptr + step;

   // --------------------------------------------------
   // stack pop, +0/2/4.
   // --------------------------------------------------
   always_comb begin
      if (!pop_en) begin
         pop_amt = '0;
      end else if (size == SZ_DWORD) begin
         pop_amt = `EX_DATA_W'd4;
      end else begin
         pop_amt = `EX_DATA_W'd2;
      end
   end

   assign sp_next = sp_data + pop_amt;

endmodule

// File: include/ex_params.svh
// widths and control-store bit positions for the execute stage.
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

`define EX_DATA_W 32   // integer datapath.
`define EX_MM_W   64   // multimedia datapath.
`define EX_CS_W   64   // control-store word.

// control-store bit positions, one bit each.
`define EX_CS_NEXT_EIP  0
`define EX_CS_NEXT_CSEG 1
`define EX_CS_SR1_SEL   2
`define EX_CS_LD_TEMP   3
`define EX_CS_B_SEL     4
`define EX_CS_SP_POP    5
`define EX_CS_SP_XCHG   6

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module execute_stage_tb --Mdir obj_dir
./obj_dir/Vexecute_stage_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"

// File: tests/execute_stage_tb.sv
// execute stage testbench with clock, stimulus, reference model, checker and watchdog.
`include "ex_params.svh"

module execute_stage_tb;
   import ex_ops_pkg::*;
   import ex_ctrl_pkg::*;

   localparam int RESET_CYCLES = 2;
   localparam int ALU_REPS     = 4;
   localparam int MM_REPS      = 4;
   localparam int B2B_REPS     = 24;
   // bundles applied including the drain cycle.
   localparam int NUM_VEC = 4 + 6 + 5 + 8 * ALU_REPS + 6 + 8 * MM_REPS + 8 + 4 + B2B_REPS + 1;
   localparam int TIMEOUT = (NUM_VEC + 20 + RESET_CYCLES) * 100;

   typedef struct packed {
      logic                  valid;
      logic [31:0]           neip;
      logic [15:0]           ncs;
      logic [`EX_CS_W-1:0]   cs;
      logic [31:0]           a;
      logic [31:0]           b;
      logic [`EX_MM_W-1:0]   mm_a;
      logic [`EX_MM_W-1:0]   mm_b;
      logic [31:0]           spx;
      logic [31:0]           mem_wr_addr;
      data_size_e            size;
      alu_op_e               aluk;
      logic [2:0]            drid1;
      logic [2:0]            drid2;
      logic                  mem_wr;
      logic                  ld_gpr1;
      logic                  ld_mm;
      logic                  df;
   } bundle_t;

   typedef struct packed {
      logic                  chk;   // slot holds a bundle to compare.
      logic                  valid;
      logic [31:0]           next_eip;
      logic [15:0]           next_cs;
      logic [`EX_CS_W-1:0]   cs;
      logic [31:0]           sr1;
      logic [31:0]           alu;
      logic [`EX_MM_W-1:0]   mm;
      logic [31:0]           spx;
      logic [31:0]           mem_wr_addr;
      data_size_e            size;
      alu_op_e               aluk;
      logic [2:0]            drid1;
      logic [2:0]            drid2;
      logic                  mem_wr;
      logic                  ld_gpr1;
      logic                  ld_mm;
   } res_t;

   logic clk, reset, in_valid, in_mem_wr, in_ld_gpr1, in_ld_mm, in_df_flag;
   logic [31:0] in_neip, in_a, in_b, in_sp_xchg_data, in_mem_wr_addr;
   logic [15:0] in_ncs;
   logic [`EX_CS_W-1:0] in_control_store;
   logic [`EX_MM_W-1:0] in_mm_a, in_mm_b;
   data_size_e in_data_size;
   alu_op_e in_aluk;
   logic [2:0] in_drid1, in_drid2;

   logic wb_valid, wb_mem_wr, wb_ld_gpr1, wb_ld_mm;
   logic [31:0] wb_next_eip, wb_sr1_data, wb_alu_result, wb_sp_xchg_out, wb_mem_wr_addr;
   logic [15:0] wb_next_cs;
   logic [`EX_CS_W-1:0] wb_control_store;
   logic [`EX_MM_W-1:0] wb_mm_result;
   data_size_e wb_data_size;
   alu_op_e wb_aluk;
   logic [2:0] wb_drid1, wb_drid2;

   integer seed = 28;
   int n_errors = 0;
   int n_checks = 0;
   logic [31:0] temp_shadow;   // model of the temp register.
   res_t exp_slot, exp_wb;

   execute_stage execute_stage_i (
      .clk (clk), .reset (reset), .in_valid (in_valid), .in_neip (in_neip),
      .in_ncs (in_ncs), .in_control_store (in_control_store), .in_a (in_a), .in_b (in_b),
      .in_mm_a (in_mm_a), .in_mm_b (in_mm_b), .in_sp_xchg_data (in_sp_xchg_data),
      .in_mem_wr_addr (in_mem_wr_addr), .in_data_size (in_data_size), .in_aluk (in_aluk),
      .in_drid1 (in_drid1), .in_drid2 (in_drid2), .in_mem_wr (in_mem_wr),
      .in_ld_gpr1 (in_ld_gpr1), .in_ld_mm (in_ld_mm), .in_df_flag (in_df_flag),
      .wb_valid (wb_valid), .wb_next_eip (wb_next_eip), .wb_next_cs (wb_next_cs),
      .wb_control_store (wb_control_store), .wb_sr1_data (wb_sr1_data),
      .wb_alu_result (wb_alu_result), .wb_mm_result (wb_mm_result),
      .wb_sp_xchg_out (wb_sp_xchg_out), .wb_mem_wr_addr (wb_mem_wr_addr),
      .wb_data_size (wb_data_size), .wb_aluk (wb_aluk), .wb_drid1 (wb_drid1),
      .wb_drid2 (wb_drid2), .wb_mem_wr (wb_mem_wr), .wb_ld_gpr1 (wb_ld_gpr1),
      .wb_ld_mm (wb_ld_mm)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // --------------------------------------------------
   // reference model.
   // --------------------------------------------------
   function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic [63:0] ext;
      logic [4:0]  sh;
      sh  = b[4:0];
      ext = {{32{a[31]}}, a} >> sh;   // sign-extended copy for sar.
      case (op)
         ADD:     return a + b;
         OR:      return a | b;
         AND:     return a & b;
         NOT_A:   return ~a;
         XOR:     return a ^ b;
         SHL:     return a << sh;
         SHR:     return a >> sh;
         SAR:     return ext[31:0];
         default: return 32'd0;
      endcase
   endfunction

   // lane-wise add or subtract with w bits per lane.
   function automatic logic [63:0] lane_ref(input logic [63:0] a, input logic [63:0] b,
                                            input int w, input logic sub);
      logic [63:0] mask, x, y, s, res;
      mask = (64'd1 << w) - 64'd1;
      res  = '0;
      for (int i = 0; i < 64; i += w) begin
         x   = (a >> i) & mask;
         y   = (b >> i) & mask;
         s   = sub ? (x - y) : (x + y);
         res = res | ((s & mask) << i);   // carry out of the lane is dropped.
      end
      return res;
   endfunction

   function automatic logic [63:0] mm_ref(input mm_op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
      case (op)
         PADDB:   return lane_ref(a, b, 8, 1'b0);
         PADDW:   return lane_ref(a, b, 16, 1'b0);
         PADDD:   return lane_ref(a, b, 32, 1'b0);
         PAND:    return a & b;
         POR:     return a | b;
         PXOR:    return a ^ b;
         PSUBB:   return lane_ref(a, b, 8, 1'b1);
         PSUBW:   return lane_ref(a, b, 16, 1'b1);
         default: return 64'd0;
      endcase
   endfunction

   function automatic res_t ref_execute(input bundle_t bv);
      res_t e;
      logic [31:0] mag, step, pop, b_op;
      case (bv.size)
         SZ_BYTE:  mag = 32'd1;
         SZ_WORD:  mag = 32'd2;
         SZ_DWORD: mag = 32'd4;
         default:  mag = 32'd0;
      endcase
      step = bv.df ? (32'd0 - mag) : mag;
      if (!bv.cs[`EX_CS_SP_POP]) pop = 32'd0;
      else if (bv.size == SZ_DWORD) pop = 32'd4;
      else pop = 32'd2;
      b_op = (b_sel_e'(bv.cs[`EX_CS_B_SEL]) == B_TEMP) ? temp_shadow : bv.b;
      e.chk         = 1'b1;
      e.valid       = bv.valid;
      e.next_eip    = bv.cs[`EX_CS_NEXT_EIP] ? bv.a : bv.neip;
      e.next_cs     = bv.cs[`EX_CS_NEXT_CSEG] ? bv.a[15:0] : bv.ncs;
      e.cs          = bv.cs;
      e.sr1         = bv.cs[`EX_CS_SR1_SEL] ? (bv.b + step) : bv.spx;
      e.spx         = bv.cs[`EX_CS_SP_XCHG] ? bv.a : (bv.spx + pop);
      e.alu         = alu_ref(bv.aluk, bv.a, b_op);
      e.mm          = mm_ref(mm_op_e'(bv.aluk), bv.mm_a, bv.mm_b);
      e.mem_wr_addr = bv.mem_wr_addr;
      e.size        = bv.size;
      e.aluk        = bv.aluk;
      e.drid1       = bv.drid1;
      e.drid2       = bv.drid2;
      e.mem_wr      = bv.mem_wr;
      e.ld_gpr1     = bv.ld_gpr1;
      e.ld_mm       = bv.ld_mm;
      return e;
   endfunction

   // --------------------------------------------------
   // stimulus helpers.
   // --------------------------------------------------
   task automatic make_random(output bundle_t bv);
      logic [31:0] r [0:13];
      for (int i = 0; i < 14; i++) r[i] = $random(seed);
      bv.valid       = 1'b1;
      bv.neip        = r[0];
      bv.ncs         = r[1][15:0];
      bv.cs          = {r[2], r[3]};
      bv.a           = r[4];
      bv.b           = r[5];
      bv.mm_a        = {r[6], r[7]};
      bv.mm_b        = {r[8], r[9]};
      bv.spx         = r[10];
      bv.mem_wr_addr = r[11];
      bv.size        = data_size_e'(2'(r[12] % 32'd3));   // legal sizes only.
      bv.aluk        = alu_op_e'(r[13][2:0]);
      bv.drid1       = r[13][5:3];
      bv.drid2       = r[13][8:6];
      bv.mem_wr      = r[13][9];
      bv.ld_gpr1     = r[13][10];
      bv.ld_mm       = r[13][11];
      bv.df          = r[13][12];
   endtask

   task automatic apply(input bundle_t bv);
      @(posedge clk);
      in_valid         <= bv.valid;
      in_neip          <= bv.neip;
      in_ncs           <= bv.ncs;
      in_control_store <= bv.cs;
      in_a             <= bv.a;
      in_b             <= bv.b;
      in_mm_a          <= bv.mm_a;
      in_mm_b          <= bv.mm_b;
      in_sp_xchg_data  <= bv.spx;
      in_mem_wr_addr   <= bv.mem_wr_addr;
      in_data_size     <= bv.size;
      in_aluk          <= bv.aluk;
      in_drid1         <= bv.drid1;
      in_drid2         <= bv.drid2;
      in_mem_wr        <= bv.mem_wr;
      in_ld_gpr1       <= bv.ld_gpr1;
      in_ld_mm         <= bv.ld_mm;
      in_df_flag       <= bv.df;
      exp_slot         <= ref_execute(bv);
      if (bv.valid && bv.cs[`EX_CS_LD_TEMP]) temp_shadow = bv.a;   // seen by later bundles.
   endtask

   task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
      n_errors++;
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
   endtask

   // one-deep slot moves along with the ex/wb register.
   always @(posedge clk) exp_wb <= exp_slot;

   // --------------------------------------------------
   // comparator at the falling edge where outputs are settled.
   // --------------------------------------------------
   always @(negedge clk) begin
      if (exp_wb.chk) begin
         n_checks++;
         if (wb_valid !== exp_wb.valid) mismatch("wb_valid", 64'(wb_valid), 64'(exp_wb.valid));
         if (wb_next_eip !== exp_wb.next_eip)
            mismatch("wb_next_eip", 64'(wb_next_eip), 64'(exp_wb.next_eip));
         if (wb_next_cs !== exp_wb.next_cs)
            mismatch("wb_next_cs", 64'(wb_next_cs), 64'(exp_wb.next_cs));
         if (wb_control_store !== exp_wb.cs)
            mismatch("wb_control_store", wb_control_store, exp_wb.cs);
         if (wb_sr1_data !== exp_wb.sr1)
            mismatch("wb_sr1_data", 64'(wb_sr1_data), 64'(exp_wb.sr1));
         if (wb_alu_result !== exp_wb.alu)
            mismatch("wb_alu_result", 64'(wb_alu_result), 64'(exp_wb.alu));
         if (wb_mm_result !== exp_wb.mm) mismatch("wb_mm_result", wb_mm_result, exp_wb.mm);
         if (wb_sp_xchg_out !== exp_wb.spx)
            mismatch("wb_sp_xchg_out", 64'(wb_sp_xchg_out), 64'(exp_wb.spx));
         if (wb_mem_wr_addr !== exp_wb.mem_wr_addr)
            mismatch("wb_mem_wr_addr", 64'(wb_mem_wr_addr), 64'(exp_wb.mem_wr_addr));
         if (wb_data_size !== exp_wb.size)
            mismatch("wb_data_size", 64'(wb_data_size), 64'(exp_wb.size));
         if (wb_aluk !== exp_wb.aluk) mismatch("wb_aluk", 64'(wb_aluk), 64'(exp_wb.aluk));
         if (wb_drid1 !== exp_wb.drid1) mismatch("wb_drid1", 64'(wb_drid1), 64'(exp_wb.drid1));
         if (wb_drid2 !== exp_wb.drid2) mismatch("wb_drid2", 64'(wb_drid2), 64'(exp_wb.drid2));
         if (wb_mem_wr !== exp_wb.mem_wr)
            mismatch("wb_mem_wr", 64'(wb_mem_wr), 64'(exp_wb.mem_wr));
         if (wb_ld_gpr1 !== exp_wb.ld_gpr1)
            mismatch("wb_ld_gpr1", 64'(wb_ld_gpr1), 64'(exp_wb.ld_gpr1));
         if (wb_ld_mm !== exp_wb.ld_mm) mismatch("wb_ld_mm", 64'(wb_ld_mm), 64'(exp_wb.ld_mm));
      end
   end

   initial begin
      #(TIMEOUT);
      $display("watchdog expired after %0d time units, run did not complete", TIMEOUT);
      $display("TESTS FAILED");
      $finish;
   end

   // --------------------------------------------------
   // test sequence.
   // --------------------------------------------------
   initial begin
      bundle_t bv;
      reset <= 1'b1;
      // a busy bundle with a temp load sits on the inputs during reset.
      in_valid <= 1'b1;
      in_neip <= '0;
      in_ncs <= '0;
      in_control_store <= '0;
      in_control_store[`EX_CS_LD_TEMP] <= 1'b1;
      in_a <= 32'hffff_ffff;
      in_b <= '0;
      in_mm_a <= '0;
      in_mm_b <= '0;
      in_sp_xchg_data <= '0;
      in_mem_wr_addr <= '0;
      in_data_size <= SZ_BYTE;
      in_aluk <= ADD;
      in_drid1 <= '0;
      in_drid2 <= '0;
      in_mem_wr <= 1'b1;
      in_ld_gpr1 <= 1'b1;
      in_ld_mm <= 1'b1;
      in_df_flag <= 1'b0;
      exp_slot <= '0;
      temp_shadow = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      in_valid <= 1'b0;
      in_control_store <= '0;
      in_a <= '0;
      in_mem_wr <= 1'b0;
      in_ld_gpr1 <= 1'b0;
      in_ld_mm <= 1'b0;
      @(negedge clk);

      // idle state right after reset.
      if (wb_valid !== 1'b0) mismatch("wb_valid after reset", 64'(wb_valid), 64'd0);
      if (wb_mem_wr !== 1'b0) mismatch("wb_mem_wr after reset", 64'(wb_mem_wr), 64'd0);
      if (wb_ld_gpr1 !== 1'b0) mismatch("wb_ld_gpr1 after reset", 64'(wb_ld_gpr1), 64'd0);
      if (wb_ld_mm !== 1'b0) mismatch("wb_ld_mm after reset", 64'(wb_ld_mm), 64'd0);

      for (int m = 0; m < 4; m++) begin   // eip and cs select.
         make_random(bv);
         bv.cs[6:0] = 7'd0;
         bv.cs[`EX_CS_NEXT_EIP] = m[0];
         bv.cs[`EX_CS_NEXT_CSEG] = m[1];
         bv.cs[`EX_CS_B_SEL] = B_TEMP;   // temp still holds its reset value.
         apply(bv);
      end
      for (int s = 0; s < 3; s++) begin   // string step in both directions.
         for (int d = 0; d < 2; d++) begin
            make_random(bv);
            bv.cs[6:0] = 7'd0;
            bv.cs[`EX_CS_SR1_SEL] = 1'b1;
            bv.size = data_size_e'(2'(s));
            bv.df = d[0];
            apply(bv);
         end
      end
      for (int p = 0; p < 5; p++) begin   // three pops by size, one xchg with pop, one plain.
         make_random(bv);
         bv.cs[6:0] = 7'd0;
         bv.cs[`EX_CS_SP_POP] = (p < 4);
         bv.cs[`EX_CS_SP_XCHG] = (p == 3);
         if (p < 3) bv.size = data_size_e'(2'(p));
         apply(bv);
      end
      for (int op = 0; op < 8; op++) begin
         for (int k = 0; k < ALU_REPS; k++) begin
            make_random(bv);
            bv.cs[6:0] = 7'd0;
            bv.aluk = alu_op_e'(op[2:0]);
            apply(bv);
         end
      end
      for (int k = 0; k < 6; k++) begin   // shl, shr, sar by 0 and 31 on negative a.
         make_random(bv);
         bv.cs[6:0] = 7'd0;
         bv.a[31] = 1'b1;
         bv.b[4:0] = (k % 2 == 1) ? 5'd31 : 5'd0;
         bv.aluk = alu_op_e'(3'(5 + k / 2));
         apply(bv);
      end
      for (int op = 0; op < 8; op++) begin
         for (int k = 0; k < MM_REPS; k++) begin
            make_random(bv);
            bv.aluk = alu_op_e'(op[2:0]);
            apply(bv);
         end
      end
      for (int op = 0; op < 8; op++) begin   // lanes that overflow or borrow.
         make_random(bv);
         bv.mm_a = 64'h80ff_7f00_ffff_0001;
         bv.mm_b = 64'h8001_8101_0001_0002;
         bv.aluk = alu_op_e'(op[2:0]);
         apply(bv);
      end

      // temp load, ignored load on an invalid bundle, then use.
      make_random(bv);
      bv.cs[6:0] = 7'd0;
      bv.cs[`EX_CS_LD_TEMP] = 1'b1;
      bv.a = 32'h1234_5678;
      apply(bv);
      make_random(bv);
      bv.valid = 1'b0;
      bv.cs[6:0] = 7'd0;
      bv.cs[`EX_CS_LD_TEMP] = 1'b1;
      bv.a = 32'hdead_beef;
      apply(bv);
      make_random(bv);
      bv.cs[6:0] = 7'd0;
      bv.cs[`EX_CS_B_SEL] = B_TEMP;
      bv.aluk = ADD;
      apply(bv);
      make_random(bv);
      bv.cs[6:0] = 7'd0;
      bv.cs[`EX_CS_B_SEL] = B_TEMP;
      bv.cs[`EX_CS_LD_TEMP] = 1'b1;   // uses the old temp and loads the new one.
      bv.aluk = OR;
      apply(bv);

      for (int k = 0; k < B2B_REPS; k++) begin   // back to back with random controls.
         make_random(bv);
         bv.valid = bv.drid1[0] | bv.drid2[0];
         apply(bv);
      end

      @(posedge clk);
      exp_slot.chk <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      $display("checks: %0d cycles compared, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
